// ==== uart_pkg.sv ====
// UART transmitter shared types for the byte, register map, serializer states and status flags
package uart_pkg;

	// Host bus data width for reads and writes
	localparam int BUS_W = 16;

	// One byte as it moves through the FIFO and serializer
	typedef logic [7:0] data_t;

	// Register map over two address bits
	typedef enum logic [1:0] {
		// Write pushes the low byte into the FIFO
		ADDR_DATA   = 2'd0,
		// Bit 0 is the transmit enable
		ADDR_CTRL   = 2'd1,
		// Bit period in clock cycles
		ADDR_DIV    = 2'd2,
		// Read gives flags and level while a write clears overflow
		ADDR_STATUS = 2'd3
	} reg_addr_t;

	// Serializer FSM states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		START = 2'd1,
		DATA  = 2'd2,
		STOP  = 2'd3
	} tx_state_t;

	// Status flags in the low nibble of a status read
	typedef struct packed {
		logic busy;
		logic overflow;
		logic full;
		logic empty;
	} status_t;

endpackage

// ==== fifo_wr_if.sv ====
// FIFO write-side bundle carrying push data and the buffer's fill flags
`timescale 1ns/1ps

interface fifo_wr_if #(
	parameter int DEPTH = 4
);
	import uart_pkg::*;

	// One extra bit so a full FIFO can report DEPTH
	localparam int LVL_W = $clog2(DEPTH) + 1;

	// Push side
	data_t            w_data;
	logic             w_en;

	// Fill state reported back by the buffer
	logic             full;
	logic             empty;
	logic [LVL_W-1:0] level;

	// Register block pushes and watches the flags
	modport producer (
		output w_data, w_en,
		input  full, empty, level
	);

	// FIFO takes pushes and owns the flags
	modport buffer (
		input  w_data, w_en,
		output full, empty, level
	);

endinterface

// ==== sync_fifo.sv ====
// Synchronous FIFO with registered flags and level, read data decoded at the read pointer
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 4
) (
	input  logic            clk,
	input  logic            rst_n,
	fifo_wr_if.buffer       wr,
	output uart_pkg::data_t r_data,
	input  logic            r_en,
	output logic            empty_out
);
	import uart_pkg::*;

	// Pointer width, DEPTH is a power of two so pointers wrap on their own
	localparam int W_ADDR = $clog2(DEPTH);
	localparam int LVL_W  = W_ADDR + 1;

	// Storage array, no reset on payload
	data_t mem [0:DEPTH-1];

	logic [W_ADDR-1:0] w_ptr;
	logic [W_ADDR-1:0] r_ptr;

	// Registered flags and fill count
	logic             full_q;
	logic             empty_q;
	logic [LVL_W-1:0] level_q;

	// Qualified transfers
	logic push;
	logic pop;

	// Push on full and pop on empty are ignored
	assign push = wr.w_en && !full_q;
	assign pop  = r_en && !empty_q;

	// Oldest entry is always visible
	assign r_data = mem[r_ptr];

	// Flags out to the interface
	assign wr.full  = full_q;
	assign wr.empty = empty_q;
	assign wr.level = level_q;

	// Same empty flag on the plain read-side port
	assign empty_out = empty_q;

	// Write into the array
	always_ff @(posedge clk) begin
		if (push) begin
			mem[w_ptr] <= wr.w_data;
		end
	end

	// Pointers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_ptr <= '0;
			r_ptr <= '0;
		end else begin
			if (push) begin
				w_ptr <= w_ptr + 1'b1;
			end
			if (pop) begin
				r_ptr <= r_ptr + 1'b1;
			end
		end
	end

	// Level and flags move only on a lone push or a lone pop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full_q  <= 1'b0;
			empty_q <= 1'b1;
			level_q <= '0;
		end else if (push && !pop) begin
			level_q <= level_q + 1'b1;
			empty_q <= 1'b0;
			// Last free slot just taken
			full_q  <= (level_q == LVL_W'(DEPTH - 1));
		end else if (pop && !push) begin
			level_q <= level_q - 1'b1;
			full_q  <= 1'b0;
			// Last entry just drained
			empty_q <= (level_q == LVL_W'(1));
		end
	end

endmodule

// ==== uart_regs.sv ====
// Host register block: decodes strobed accesses, pushes bytes, holds control and overflow
`timescale 1ns/1ps

module uart_regs #(
	parameter int DEPTH     = 4,
	parameter int DIV_RESET = 4
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  uart_pkg::reg_addr_t      bus_addr,
	input  logic [uart_pkg::BUS_W-1:0] bus_wdata,
	input  logic                     bus_wen,
	input  logic                     bus_ren,
	output logic [uart_pkg::BUS_W-1:0] bus_rdata,
	fifo_wr_if.producer              wr,
	input  logic                     busy,
	output logic                     tx_en,
	output logic [uart_pkg::BUS_W-1:0] divider
);
	import uart_pkg::*;

	localparam int LVL_W = $clog2(DEPTH) + 1;

	logic             data_wr;
	logic             ovf_clr;
	logic             overflow;
	logic [LVL_W-1:0] level;
	logic [7:0]       level_byte;
	status_t          status;

	// Address decode for writes
	assign data_wr = bus_wen && (bus_addr == ADDR_DATA);
	assign ovf_clr = bus_wen && (bus_addr == ADDR_STATUS);

	// Push goes out in the same cycle as the write strobe
	assign wr.w_en   = data_wr;
	assign wr.w_data = bus_wdata[7:0];

	// Level widened into the status top byte
	assign level      = wr.level;
	assign level_byte = 8'(level);

	// Live status flags
	assign status.busy     = busy;
	assign status.overflow = overflow;
	assign status.full     = wr.full;
	assign status.empty    = wr.empty;

	// Control and divider registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_en   <= 1'b0;
			divider <= BUS_W'(DIV_RESET);
		end else if (bus_wen) begin
			if (bus_addr == ADDR_CTRL) begin
				tx_en <= bus_wdata[0];
			end
			if (bus_addr == ADDR_DIV) begin
				divider <= bus_wdata;
			end
		end
	end

	// Sticky overflow, a new drop beats a same-cycle clear
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			overflow <= 1'b0;
		end else if (data_wr && wr.full) begin
			overflow <= 1'b1;
		end else if (ovf_clr) begin
			overflow <= 1'b0;
		end
	end

	// Registered read data, held until the next read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_rdata <= '0;
		end else if (bus_ren) begin
			case (bus_addr)
				ADDR_CTRL:   bus_rdata <= {{(BUS_W-1){1'b0}}, tx_en};
				ADDR_DIV:    bus_rdata <= divider;
				ADDR_STATUS: bus_rdata <= {level_byte, 4'b0000, status};
				// Data register is write-only
				default:     bus_rdata <= '0;
			endcase
		end
	end

endmodule

// ==== uart_tx.sv ====
// 8N1 serializer: pops bytes from the FIFO and shifts them out at the programmed bit period
`timescale 1ns/1ps

module uart_tx (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       tx_en,
	input  logic [uart_pkg::BUS_W-1:0] divider,
	input  uart_pkg::data_t            r_data,
	input  logic                       empty,
	output logic                       r_en,
	output logic                       busy,
	output logic                       tx
);
	import uart_pkg::*;

	tx_state_t        state;
	logic [BUS_W-1:0] bit_cnt;
	logic [BUS_W-1:0] bit_div;
	logic [BUS_W-1:0] div_eff;
	logic [2:0]       bit_idx;
	data_t            shift;
	logic             bit_end;

	// Divider of 0 behaves as 1
	assign div_eff = (divider == '0) ? BUS_W'(1) : divider;

	// Pop only from IDLE, only when enabled and data is there
	assign r_en = (state == IDLE) && tx_en && !empty;

	// Busy covers the pop cycle and the whole frame
	assign busy = (state != IDLE) || r_en;

	// Last cycle of the current bit
	assign bit_end = (bit_cnt == '0);

	// Frame FSM with bit-period down-counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= IDLE;
			tx      <= 1'b1;
			bit_cnt <= '0;
			bit_div <= BUS_W'(1);
			bit_idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (r_en) begin
						// Divider frozen for the whole frame
						bit_div <= div_eff;
						bit_cnt <= div_eff - 1'b1;
						bit_idx <= '0;
						tx      <= 1'b0;
						state   <= START;
					end
				end
				START: begin
					if (bit_end) begin
						// LSB goes first
						tx      <= shift[0];
						bit_cnt <= bit_div - 1'b1;
						state   <= DATA;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_div - 1'b1;
						if (bit_idx == 3'd7) begin
							tx    <= 1'b1;
							state <= STOP;
						end else begin
							tx      <= shift[0];
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				STOP: begin
					if (bit_end) begin
						// Line stays high, next pop can follow at once
						state <= IDLE;
					end else begin
						bit_cnt <= bit_cnt - 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Shift register, loaded on the pop and advanced at each bit boundary
	always_ff @(posedge clk) begin
		if (r_en) begin
			shift <= r_data;
		end else if (bit_end && ((state == START) || (state == DATA))) begin
			shift <= shift >> 1;
		end
	end

endmodule

// ==== uart_tx_top.sv ====
// UART transmitter top: register block feeding a FIFO drained by the serializer
`timescale 1ns/1ps

module uart_tx_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int DIV_RESET  = 4
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  uart_pkg::reg_addr_t        bus_addr,
	input  logic [uart_pkg::BUS_W-1:0] bus_wdata,
	input  logic                       bus_wen,
	input  logic                       bus_ren,
	output logic [uart_pkg::BUS_W-1:0] bus_rdata,
	output logic                       tx
);
	import uart_pkg::*;

	// FIFO read side
	data_t            r_data;
	logic             r_en;
	logic             fifo_empty;

	// Control from registers, status back from the serializer
	logic             tx_en;
	logic [BUS_W-1:0] divider;
	logic             busy;

	// Write side of the FIFO
	fifo_wr_if #(.DEPTH(FIFO_DEPTH)) fifo_wr ();

	uart_regs #(
		.DEPTH     (FIFO_DEPTH),
		.DIV_RESET (DIV_RESET)
	) u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_wen   (bus_wen),
		.bus_ren   (bus_ren),
		.bus_rdata (bus_rdata),
		.wr        (fifo_wr.producer),
		.busy      (busy),
		.tx_en     (tx_en),
		.divider   (divider)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr        (fifo_wr.buffer),
		.r_data    (r_data),
		.r_en      (r_en),
		.empty_out (fifo_empty)
	);

	uart_tx u_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.tx_en   (tx_en),
		.divider (divider),
		.r_data  (r_data),
		.empty   (fifo_empty),
		.r_en    (r_en),
		.busy    (busy),
		.tx      (tx)
	);

endmodule

// ==== uart_tx_checker.sv ====
// Bound assertions on the UART transmitter top for FIFO flags, the pop rule and the idle line
`timescale 1ns/1ps

module uart_tx_checker #(
	parameter int DEPTH = 4
) (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   full,
	input logic                   empty,
	input logic [$clog2(DEPTH):0] level,
	input logic                   r_en,
	input logic                   busy,
	input logic                   tx
);

	// FIFO cannot be full and empty at once
	flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
		else $error("FIFO reports full and empty together");

	// Level stays within the array size
	level_bound: assert property (@(posedge clk) disable iff (!rst_n) level <= DEPTH)
		else $error("FIFO level above depth");

	// A pop must find a nonzero count in the FIFO level register
	pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) r_en |-> (level != '0))
		else $error("Pop while FIFO empty");

	// Idle line is high
	idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
		else $error("tx low while serializer idle");

endmodule

bind uart_tx_top uart_tx_checker #(.DEPTH(FIFO_DEPTH)) u_checker (
	.clk   (clk),
	.rst_n (rst_n),
	.full  (fifo_wr.full),
	.empty (fifo_empty),
	.level (fifo_wr.level),
	.r_en  (r_en),
	.busy  (busy),
	.tx    (tx)
);

// ==== tb_uart_tx.sv ====
// Testbench for the UART transmitter: table-driven loads, serial receiver model, status checks
`timescale 1ns/1ps

module tb_uart_tx;
	import uart_pkg::*;

	localparam int NROWS = 5;

	logic             clk;
	logic             rst_n;
	reg_addr_t        bus_addr;
	logic [BUS_W-1:0] bus_wdata;
	logic             bus_wen;
	logic             bus_ren;
	logic [BUS_W-1:0] bus_rdata;
	logic             tx;

	// Stimulus table: divider, byte count, expected flags after loading, random bytes
	logic [BUS_W-1:0] row_div [NROWS] = '{16'd4, 16'd1, 16'd0, 16'd7, 16'd2};
	int               row_cnt [NROWS] = '{4, 3, 2, 1, 0};
	status_t          row_status [NROWS] = '{4'b0010, 4'b0000, 4'b0000, 4'b0000, 4'b0001};
	data_t            row_bytes [NROWS][4];

	// Receiver model state
	data_t      rx_q[$];
	data_t      exp_q[$];
	int         rx_div = 4;
	int         rx_cnt = 0;
	int         rx_starts = 0;
	logic       rx_active;
	logic       rx_prev;
	logic       rx_ref;
	logic       rx_bad;
	logic [9:0] rx_bits;

	int errors = 0;
	int err_base = 0;
	int tests = 0;
	int tests_failed = 0;

	uart_tx_top #(.FIFO_DEPTH(4), .DIV_RESET(4)) dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_wen   (bus_wen),
		.bus_ren   (bus_ren),
		.bus_rdata (bus_rdata),
		.tx        (tx)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Serial receiver, samples tx between edges and checks each bit holds for a whole period
	always @(negedge clk) begin : rx_model
		int k;
		int pos;
		if (!rst_n) begin
			rx_active = 1'b0;
			rx_prev = 1'b1;
		end else begin
			// Falling edge on an idle line opens a frame
			if (!rx_active && rx_prev && !tx) begin
				rx_active = 1'b1;
				rx_cnt = 0;
				rx_bad = 1'b0;
				rx_starts++;
			end
			if (rx_active) begin
				k = rx_cnt / rx_div;
				pos = rx_cnt % rx_div;
				if (pos == 0) begin
					rx_ref = tx;
				end else if (tx !== rx_ref) begin
					rx_bad = 1'b1;
				end
				// Mid-bit sample
				if (pos == rx_div / 2) begin
					rx_bits[k] = tx;
				end
				rx_cnt++;
				if (rx_cnt == 10 * rx_div) begin
					rx_active = 1'b0;
					if (rx_bad || rx_bits[0] !== 1'b0 || rx_bits[9] !== 1'b1) begin
						$display("FAIL t=%0t framing error, frame bits %b", $time, rx_bits);
						errors++;
					end
					rx_q.push_back(rx_bits[8:1]);
				end
			end
			rx_prev = tx;
		end
	end

	task automatic bus_write(input reg_addr_t addr, input logic [BUS_W-1:0] data);
		@(posedge clk);
		bus_addr  <= addr;
		bus_wdata <= data;
		bus_wen   <= 1'b1;
		@(posedge clk);
		bus_wen   <= 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t addr, output logic [BUS_W-1:0] data);
		@(posedge clk);
		bus_addr <= addr;
		bus_ren  <= 1'b1;
		@(posedge clk);
		bus_ren  <= 1'b0;
		// Read data is registered on the sampling edge
		@(negedge clk);
		data = bus_rdata;
	endtask

	task automatic compare_byte(input data_t got, input data_t exp, input int idx);
		if (got !== exp) begin
			$display("FAIL t=%0t byte %0d: got %02h expected %02h", $time, idx, got, exp);
			errors++;
		end
	endtask

	task automatic compare_status(input status_t got, input logic [7:0] got_level,
			input status_t exp, input logic [7:0] exp_level);
		if (got !== exp || got_level !== exp_level) begin
			$display("FAIL t=%0t status: got flags %b level %0d, expected flags %b level %0d",
				$time, got, got_level, exp, exp_level);
			errors++;
		end
	endtask

	task automatic expect_status(input status_t exp, input logic [7:0] exp_level);
		logic [BUS_W-1:0] word;
		bus_read(ADDR_STATUS, word);
		compare_status(status_t'(word[3:0]), word[15:8], exp, exp_level);
	endtask

	task automatic write_byte(input data_t b);
		bus_write(ADDR_DATA, {8'h00, b});
		exp_q.push_back(b);
	endtask

	task automatic wait_rx(input int n, input int limit);
		int cyc;
		cyc = 0;
		while (rx_q.size() < n && cyc < limit) begin
			@(negedge clk);
			cyc++;
		end
		if (rx_q.size() < n) begin
			$display("Timeout: receiver got %0d of %0d bytes", rx_q.size(), n);
			errors++;
		end
	endtask

	task automatic wait_frame_start(input int limit);
		int cyc;
		cyc = 0;
		while (!rx_active && cyc < limit) begin
			@(negedge clk);
			cyc++;
		end
		if (!rx_active) begin
			$display("Timeout: no frame started on tx");
			errors++;
		end
	endtask

	// Received bytes against the bytes the FIFO accepted
	task automatic check_rx();
		int i;
		i = 0;
		if (rx_q.size() != exp_q.size()) begin
			$display("Receiver got %0d bytes where %0d were expected", rx_q.size(), exp_q.size());
			errors++;
		end
		while (rx_q.size() > 0 && exp_q.size() > 0) begin
			compare_byte(rx_q.pop_front(), exp_q.pop_front(), i);
			i++;
		end
		rx_q.delete();
		exp_q.delete();
	endtask

	task automatic test_end(input string name);
		tests++;
		if (errors == err_base) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests, name, errors - err_base);
		end
	endtask

	initial begin
		int starts;
		data_t b;
		rst_n     = 1'b0;
		bus_addr  = ADDR_DATA;
		bus_wdata = '0;
		bus_wen   = 1'b0;
		bus_ren   = 1'b0;
		void'($urandom(32'h8aa2_9b54));
		for (int r = 0; r < NROWS; r++) begin
			for (int i = 0; i < 4; i++) begin
				row_bytes[r][i] = data_t'($urandom);
			end
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// Reset state, line idle
		err_base = errors;
		expect_status(4'b0001, 8'd0);
		repeat (8) begin
			@(negedge clk);
			if (tx !== 1'b1) begin
				$display("FAIL t=%0t tx not idle high after reset", $time);
				errors++;
			end
		end
		test_end("reset");

		// Table rows: load while disabled, then enable and receive
		for (int r = 0; r < NROWS; r++) begin
			err_base = errors;
			starts = rx_starts;
			bus_write(ADDR_DIV, row_div[r]);
			rx_div = (row_div[r] == 0) ? 1 : int'(row_div[r]);
			for (int i = 0; i < row_cnt[r]; i++) begin
				write_byte(row_bytes[r][i]);
			end
			expect_status(row_status[r], 8'(row_cnt[r]));
			if (rx_starts != starts) begin
				$display("A frame went out on tx while transmit was disabled");
				errors++;
			end
			bus_write(ADDR_CTRL, 16'h0001);
			wait_rx(row_cnt[r], row_cnt[r] * (10 * rx_div + 4) + 40);
			check_rx();
			expect_status(4'b0001, 8'd0);
			bus_write(ADDR_CTRL, 16'h0000);
			test_end($sformatf("row %0d div %0d count %0d", r, row_div[r], row_cnt[r]));
		end

		// Overflow: six writes into four slots
		err_base = errors;
		for (int i = 0; i < 6; i++) begin
			b = data_t'($urandom);
			bus_write(ADDR_DATA, {8'h00, b});
			if (i < 4) begin
				exp_q.push_back(b);
			end
		end
		expect_status(4'b0110, 8'd4);
		bus_write(ADDR_CTRL, 16'h0001);
		wait_rx(4, 4 * (10 * rx_div + 4) + 40);
		check_rx();
		expect_status(4'b0101, 8'd0);
		bus_write(ADDR_STATUS, 16'h0000);
		expect_status(4'b0001, 8'd0);
		bus_write(ADDR_CTRL, 16'h0000);
		test_end("overflow");

		// Disable partway through a frame, the frame still completes
		err_base = errors;
		bus_write(ADDR_DIV, 16'd4);
		rx_div = 4;
		write_byte(data_t'($urandom));
		write_byte(data_t'($urandom));
		bus_write(ADDR_CTRL, 16'h0001);
		wait_frame_start(200);
		repeat (12) @(negedge clk);
		bus_write(ADDR_CTRL, 16'h0000);
		wait_rx(1, 100);
		repeat (60) @(negedge clk);
		// Second byte held back
		expect_status(4'b0000, 8'd1);
		bus_write(ADDR_CTRL, 16'h0001);
		wait_rx(2, 100);
		check_rx();
		expect_status(4'b0001, 8'd0);
		test_end("disable mid-frame");

		$display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== build.f ====
uart_pkg.sv
fifo_wr_if.sv
sync_fifo.sv
uart_regs.sv
uart_tx.sv
uart_tx_top.sv
uart_tx_checker.sv
tb_uart_tx.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_uart_tx \
	-Mdir obj_dir -o tb_uart_tx > sim.log 2>&1 \
	&& ./obj_dir/tb_uart_tx >> sim.log 2>&1 \
	|| { cat sim.log; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qF "*** FAILED ***" sim.log && exit 1 || exit 0
